// File: common/fma16_defines.svh
/*
 * widths, exponent limits and fixed encodings
 * for the half-precision fused multiply-add
 */
`ifndef FMA16_DEFINES_SVH
`define FMA16_DEFINES_SVH

// word layout
`define FP_W        16
`define EXP_W       5
`define FRAC_W      10
`define SIG_W       11

// product and aligned-sum widths
`define PROD_W      22
// product + carry bit + two guard bits
`define SUM_W       25
// signed working exponent, covers product range and normalize shifts
`define XEXP_W      8

// exponent limits
`define EXP_BIAS    15
`define EXP_MAX     31

// fixed encodings
`define QNAN_WORD   16'h7E00
`define ONE_WORD    16'h3C00
// magnitudes without sign bit
`define INF_MAG     15'h7C00
`define MAXNUM_MAG  15'h7BFF

`endif

// File: common/fma16_pkg.sv
/*
 * shared types for the fma16 unit
 * half-precision word union and rounding-mode encoding
 */
`include "fma16_defines.svh"

package fma16_pkg;

    // one half-precision word, seen as plain fields or as a NaN
    typedef union packed {
        struct packed {
            logic              sign;
            logic [`EXP_W-1:0]  exp;
            logic [`FRAC_W-1:0] frac;
        } fld;
        struct packed {
            logic              sign;
            logic [`EXP_W-1:0]  exp;
            // msb of the fraction, set for quiet NaN
            logic              quiet;
            logic [`FRAC_W-2:0] payload;
        } nan;
    } fp16_u;

    // rounding modes
    typedef enum logic [1:0] {
        rm_rz  = 2'b00,
        rm_rne = 2'b01,
        rm_rd  = 2'b10,
        rm_ru  = 2'b11
    } round_mode_e;

endpackage

// File: datapath/fma16_add_norm.sv
/*
 * effective add or subtract of the aligned terms,
 * leading-zero count, left normalization
 * and the result sign
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_add_norm import fma16_pkg::*; (
    input  logic [`SUM_W-1:0]         big_sig,
    input  logic [`SUM_W-1:0]         small_sig,
    input  logic signed [`XEXP_W-1:0] ref_exp,
    input  logic                      sticky,
    input  logic                      eff_sub,
    input  logic                      prod_sign,
    input  logic                      prod_big,
    input  logic                      z_sign,
    input  logic                      prod_zero,
    input  logic                      addend_zero,
    input  round_mode_e               roundmode,
    output logic [`SUM_W-1:0]         norm_sig,
    output logic signed [`XEXP_W-1:0] norm_exp,
    output logic                      res_sign,
    output logic                      exact_zero
);

    logic [`SUM_W-1:0] sum;
    logic [4:0]        lzc;
    logic              zero_neg;

    // lost bits of the small term borrow one lsb when subtracting
    assign sum = eff_sub ? (big_sig - small_sig - `SUM_W'(sticky))
                         : (big_sig + small_sig);

    // priority scan, highest set bit wins
    always_comb begin
        lzc = 5'(`SUM_W);
        for (int i = 0; i < `SUM_W; i++) begin
            if (sum[i]) begin
                lzc = 5'(`SUM_W - 1 - i);
            end
        end
    end

    // leading one ends up at the msb
    assign norm_sig = sum << lzc;

    // binary point is one below the carry bit
    assign norm_exp = ref_exp + `XEXP_W'(1) - `XEXP_W'(lzc);

    assign exact_zero = (sum == '0);

    // cancellation is -0 only rounding down
    // two negative zeros stay negative
    assign zero_neg = ((roundmode == rm_rd) & eff_sub)
                    | (prod_zero & addend_zero & prod_sign & z_sign);

    // otherwise the larger term sets the sign
    always_comb begin
        if (exact_zero) begin
            res_sign = zero_neg;
        end else if (prod_big) begin
            res_sign = prod_sign;
        end else begin
            res_sign = z_sign;
        end
    end

endmodule

// File: datapath/fma16_mul_align.sv
/*
 * significand product and product exponent,
 * magnitude ordering of product and addend,
 * right alignment of the smaller term with sticky
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_mul_align import fma16_pkg::*; (
    input  fp16_u                     x,
    input  fp16_u                     y_sel,
    input  fp16_u                     z_sel,
    output logic                      prod_sign,
    output logic                      prod_big,
    output logic                      eff_sub,
    output logic [`SUM_W-1:0]         big_sig,
    output logic [`SUM_W-1:0]         small_sig,
    output logic signed [`XEXP_W-1:0] ref_exp,
    output logic                      sticky,
    output logic                      prod_zero,
    output logic                      addend_zero
);

    logic [`PROD_W-1:0]         prod_raw;
    logic [`PROD_W-1:0]         prod_n;
    logic [`PROD_W-1:0]         addend_n;
    logic signed [`XEXP_W-1:0]  x_exp, y_exp, add_exp;
    logic signed [`XEXP_W-1:0]  prod_exp;
    logic signed [`XEXP_W-1:0]  exp_diff;
    logic [`SUM_W-1:0]          prod_win, add_win;
    logic [4:0]                 shamt;
    logic [2*`SUM_W-1:0]        shift_buf;

    assign prod_sign = x.fld.sign ^ y_sel.fld.sign;
    assign eff_sub   = prod_sign ^ z_sel.fld.sign;

    // exponent zero means zero, subnormals included
    assign prod_zero   = (x.fld.exp == '0) | (y_sel.fld.exp == '0);
    assign addend_zero = (z_sel.fld.exp == '0);

    // 11x11 product, value in [1,4)
    assign prod_raw = {1'b1, x.fld.frac} * {1'b1, y_sel.fld.frac};

    assign x_exp   = `XEXP_W'(x.fld.exp);
    assign y_exp   = `XEXP_W'(y_sel.fld.exp);
    assign add_exp = `XEXP_W'(z_sel.fld.exp);

    // normalize so the leading one sits at the msb
    assign prod_n   = prod_raw[`PROD_W-1] ? prod_raw : (prod_raw << 1);
    assign prod_exp = x_exp + y_exp - `XEXP_W'(`EXP_BIAS)
                    + `XEXP_W'(prod_raw[`PROD_W-1]);

    // addend lined up with the normalized product
    assign addend_n = {1'b1, z_sel.fld.frac, {(`PROD_W-`SIG_W){1'b0}}};

    // larger exponent wins, ties go to the larger significand
    assign prod_big = addend_zero
                    | (!prod_zero & ((prod_exp > add_exp)
                    | ((prod_exp == add_exp) & (prod_n >= addend_n))));

    // sum window is carry bit, term, two guard bits
    assign prod_win = prod_zero ? '0 : {1'b0, prod_n, 2'b00};
    assign add_win  = addend_zero ? '0 : {1'b0, addend_n, 2'b00};

    assign big_sig   = prod_big ? prod_win : add_win;
    assign ref_exp   = prod_big ? prod_exp : add_exp;
    assign exp_diff  = prod_big ? (prod_exp - add_exp) : (add_exp - prod_exp);

    // past the whole window everything lands in sticky
    assign shamt = (exp_diff > `XEXP_W'(`SUM_W)) ? 5'(`SUM_W) : exp_diff[4:0];

    // low half of the buffer catches the shifted-out bits
    assign shift_buf = {(prod_big ? add_win : prod_win), {`SUM_W{1'b0}}} >> shamt;

    assign small_sig = shift_buf[2*`SUM_W-1:`SUM_W];
    assign sticky    = |shift_buf[`SUM_W-1:0];

endmodule

// File: datapath/fma16_round.sv
/*
 * rounding by mode with guard and sticky,
 * carry into the exponent, raw overflow
 * and underflow indications
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_round import fma16_pkg::*; (
    input  logic [`SUM_W-1:0]         norm_sig,
    input  logic signed [`XEXP_W-1:0] norm_exp,
    input  logic                      res_sign,
    input  logic                      sticky,
    input  round_mode_e               roundmode,
    output fp16_u                     rounded_word,
    output logic                      ovf,
    output logic                      unf,
    output logic                      inexact
);

    logic [`FRAC_W-1:0]        frac_t;
    logic                      guard;
    logic                      rest;
    logic                      round_up;
    logic [`FRAC_W:0]          frac_r;
    logic signed [`XEXP_W-1:0] exp_r;

    // hidden one at msb, then fraction, then guard
    assign frac_t = norm_sig[`SUM_W-2 -: `FRAC_W];
    assign guard  = norm_sig[`SUM_W-2-`FRAC_W];
    assign rest   = (|norm_sig[`SUM_W-3-`FRAC_W:0]) | sticky;

    always_comb begin
        case (roundmode)
            rm_rz:   round_up = 1'b0;
            // ties go to even
            rm_rne:  round_up = guard & (rest | frac_t[0]);
            rm_rd:   round_up = res_sign & (guard | rest);
            default: round_up = !res_sign & (guard | rest);
        endcase
    end

    // all-ones fraction wraps to zero and bumps the exponent
    assign frac_r = {1'b0, frac_t} + `SIG_W'(round_up);
    assign exp_r  = norm_exp + `XEXP_W'(frac_r[`FRAC_W]);

    assign rounded_word = {res_sign, exp_r[`EXP_W-1:0], frac_r[`FRAC_W-1:0]};

    assign ovf = (exp_r >= `XEXP_W'(`EXP_MAX));
    // below the smallest normal, flushed later
    assign unf = (exp_r < `XEXP_W'(1));

    assign inexact = guard | rest | ovf | unf;

endmodule

// File: sim/fma16_model.svh
/*
 * reference model for the fma16 unit
 * exact product and sum in wide integers, one rounding step,
 * flush of results below the normal range
 */
`ifndef FMA16_MODEL_SVH
`define FMA16_MODEL_SVH

`include "fma16_defines.svh"

// returns {result, flags}, flags are {invalid, overflow, underflow, inexact}
// ctl is {mul, add, negp, negz}
function automatic logic [19:0] fma16_model(
    input logic [15:0] xv,
    input logic [15:0] yv,
    input logic [15:0] zv,
    input logic [3:0]  ctl,
    input logic [1:0]  rm
);
    logic [15:0]  op [3];
    logic [2:0]   is_nan, is_snan, is_inf, is_zero;
    logic         sp, sz, sr, invalid, guard, rest, up;
    logic [127:0] pm, zm, mag;
    logic [11:0]  kept;
    int           ex, ey, ez, msb, sh, ebias;

    // mul low gives y = +1, add low gives z = +0
    op[0] = xv;
    op[1] = ctl[3] ? {yv[15] ^ ctl[1], yv[14:0]} : `ONE_WORD;
    op[2] = ctl[2] ? {zv[15] ^ ctl[0], zv[14:0]} : 16'h0000;
    for (int i = 0; i < 3; i++) begin
        is_inf[i]  = (op[i][14:10] == 5'h1f) && (op[i][9:0] == 10'h000);
        is_nan[i]  = (op[i][14:10] == 5'h1f) && (op[i][9:0] != 10'h000);
        is_snan[i] = is_nan[i] && !op[i][9];
        // subnormal inputs count as zero
        is_zero[i] = (op[i][14:10] == 5'h00);
    end
    sp = op[0][15] ^ op[1][15];
    sz = op[2][15];

    // any NaN or infinity decides the result alone
    if (|is_nan || |is_inf) begin
        invalid = |is_snan || (is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1])
               || ((is_inf[0] || is_inf[1]) && is_inf[2] && (sp != sz));
        if (|is_nan || invalid)
            return {`QNAN_WORD, invalid, 3'b000};
        sr = (is_inf[0] || is_inf[1]) ? sp : sz;
        return {sr, `INF_MAG, 4'b0000};
    end

    // exact magnitudes scaled by 2^48, everything integral
    ex = op[0][14:10];
    ey = op[1][14:10];
    ez = op[2][14:10];
    pm = 128'({1'b1, op[0][9:0]}) * 128'({1'b1, op[1][9:0]});
    pm = (is_zero[0] || is_zero[1]) ? 128'd0 : (pm << (ex + ey - 2));
    zm = is_zero[2] ? 128'd0 : (128'({1'b1, op[2][9:0]}) << (ez + 23));

    // signed sum, the larger magnitude gives the sign
    if (sp == sz) begin
        mag = pm + zm;
        sr  = sp;
    end else if (pm >= zm) begin
        mag = pm - zm;
        sr  = sp;
    end else begin
        mag = zm - pm;
        sr  = sz;
    end

    if (mag == 128'd0) begin
        // -0 only for rounding down with opposite signs, or two negative zeros
        sr = ((rm == 2'b10) && (sp != sz)) || ((pm == 0) && (zm == 0) && sp && sz);
        return {sr, 15'h0000, 4'b0000};
    end

    msb = 0;
    for (int i = 0; i < 128; i++) begin
        if (mag[i])
            msb = i;
    end
    // 11 significant bits kept, the guard right below, the rest sticky
    sh    = msb - 10;
    kept  = 12'(mag >> sh);
    guard = mag[sh-1];
    rest  = (mag & ((128'd1 << (sh - 1)) - 128'd1)) != 128'd0;
    ebias = msb - 33;

    case (rm)
        2'b00:   up = 1'b0;
        2'b01:   up = guard && (rest || kept[0]);
        2'b10:   up = sr && (guard || rest);
        default: up = !sr && (guard || rest);
    endcase
    kept = kept + 12'(up);
    // carry out of the significand moves the exponent up
    if (kept[11]) begin
        kept  = kept >> 1;
        ebias = ebias + 1;
    end

    if (ebias >= `EXP_MAX) begin
        // modes rounding toward zero for this sign stop at the largest finite value
        if ((rm == 2'b00) || ((rm == 2'b10) && !sr) || ((rm == 2'b11) && sr))
            return {sr, `MAXNUM_MAG, 4'b0101};
        return {sr, `INF_MAG, 4'b0101};
    end
    if (ebias < 1)
        return {sr, 15'h0000, 4'b0011};
    return {sr, 5'(ebias), kept[9:0], 3'b000, guard || rest};
endfunction

`endif

// File: sim/tb_fma16.sv
/*
 * testbench for the fma16 unit
 * clock, reset, LCG stimulus, test sequences,
 * model comparison and the closing summary
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module tb_fma16 import fma16_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 300;
    localparam int N_SPEC       = 300;
    localparam int N_EXTREME    = 300;
    localparam int N_CANCEL     = 200;
    localparam int N_STREAM     = 1000;
    // isolated ops take two cycles and streams one each plus a drain
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 + 2 * N_RAND + (N_SPEC + 1)
                                + (N_EXTREME + 1) + (N_CANCEL + 1) + (N_STREAM + 1) + 100;

    logic        clk;
    logic        arst_n;
    fp16_u       x, y, z;
    logic        mul, add, negp, negz;
    round_mode_e roundmode;
    fp16_u       result;
    logic [3:0]  flags;

    logic [31:0] seed;
    int          cycles;
    int          checks, test_errors, total_checks, total_errors;
    logic        have_prev;
    logic [19:0] prev_exp;
    string       prev_ctx;

    `include "fma16_model.svh"

    fma16 i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .x         (x),
        .y         (y),
        .z         (z),
        .mul       (mul),
        .add       (add),
        .negp      (negp),
        .negz      (negz),
        .roundmode (roundmode),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit from the test lengths
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // exponent 8..22 keeps most results in the normal range
    function automatic logic [15:0] normal_operand();
        logic [31:0] r;
        r = next_rand();
        return {r[31], 5'(8 + r[20:16] % 15), r[9:0]};
    endfunction

    function automatic logic [15:0] special_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return {r[31], 15'h0000};
            3'd1:    return {r[31], `INF_MAG};
            3'd2:    return {r[31], 5'h1f, 1'b1, r[24:16]};
            // signaling NaN needs a nonzero payload
            3'd3:    return {r[31], 5'h1f, 1'b0, r[24:17], 1'b1};
            3'd4:    return {r[31], 5'h00, r[25:16] | 10'h001};
            default: return normal_operand();
        endcase
    endfunction

    // exponent 24..30 when big and 1..6 otherwise
    function automatic logic [15:0] extreme_operand(input logic big);
        logic [31:0] r;
        r = next_rand();
        if (big)
            return {r[30], 5'(24 + r[20:16] % 7), r[9:0]};
        return {r[30], 5'(1 + r[20:16] % 6), r[9:0]};
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h (%s)", name, got, exp, prev_ctx);
            test_errors++;
        end
    endtask

    task automatic compare_prev();
        check_val("result", result, prev_exp[19:4]);
        check_val("flags", 16'(flags), 16'(prev_exp[3:0]));
    endtask

    // drive one op and check the op before it at this negedge
    task automatic issue(input logic [15:0] xv, input logic [15:0] yv,
                         input logic [15:0] zv, input logic [3:0] ctl, input logic [1:0] rm);
        @(posedge clk);
        x                      <= xv;
        y                      <= yv;
        z                      <= zv;
        {mul, add, negp, negz} <= ctl;
        roundmode              <= round_mode_e'(rm);
        @(negedge clk);
        if (have_prev)
            compare_prev();
        prev_exp  = fma16_model(xv, yv, zv, ctl, rm);
        prev_ctx  = $sformatf("x=%h y=%h z=%h mul,add,negp,negz=%b rm=%0d",
                              xv, yv, zv, ctl, rm);
        have_prev = 1'b1;
    endtask

    task automatic drain();
        @(posedge clk);
        @(negedge clk);
        if (have_prev)
            compare_prev();
        have_prev = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("test %-24s %5d checks %4d errors", name, checks, test_errors);
        total_checks += checks;
        total_errors += test_errors;
        checks      = 0;
        test_errors = 0;
    endtask

    initial begin : main_seq
        logic [31:0] r;
        logic [15:0] xv, yv, zv;
        logic        big, zs;
        seed         = 32'hca16185c;
        checks       = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        have_prev    = 1'b0;
        prev_ctx     = "reset";
        arst_n       = 1'b0;
        // inexact product held at the inputs, nonzero result and flags without reset
        x            = 16'h3C01;
        y            = 16'h3C01;
        z            = '0;
        {mul, add, negp, negz} = 4'b1000;
        roundmode    = rm_rz;

        // outputs stay clear during reset and on the release edge
        for (int i = 0; i <= RESET_CYCLES; i++) begin
            if (i == RESET_CYCLES) begin
                @(posedge clk);
                arst_n <= 1'b1;
            end
            @(negedge clk);
            check_val("result", result, 16'h0000);
            check_val("flags", 16'(flags), 16'h0000);
        end
        end_test("reset");

        for (int i = 0; i < N_RAND; i++) begin
            r  = next_rand();
            xv = normal_operand();
            yv = normal_operand();
            zv = normal_operand();
            issue(xv, yv, zv, r[3:0], r[5:4]);
            drain();
        end
        end_test("random normal");

        // mul and add mostly enabled so the specials reach both terms
        for (int i = 0; i < N_SPEC; i++) begin
            r  = next_rand();
            xv = special_operand();
            yv = special_operand();
            zv = special_operand();
            issue(xv, yv, zv, {r[3] | r[6], r[2] | r[7], r[1:0]}, r[5:4]);
        end
        drain();
        end_test("special values");

        for (int i = 0; i < N_EXTREME; i++) begin
            r   = next_rand();
            big = r[8];
            xv  = extreme_operand(big);
            yv  = extreme_operand(big);
            zv  = extreme_operand(big);
            issue(xv, yv, zv, {1'b1, r[2:0]}, r[5:4]);
        end
        drain();
        end_test("overflow and underflow");

        // y a power of two keeps x*y exact and z is its negation
        for (int i = 0; i < N_CANCEL; i++) begin
            r  = next_rand();
            xv = normal_operand();
            yv = {r[31], 5'(10 + r[20:16] % 11), 10'h000};
            zs = !(xv[15] ^ yv[15] ^ r[1]) ^ r[0];
            zv = {zs, 5'(xv[14:10] + yv[14:10] - `EXP_BIAS), xv[9:0]};
            issue(xv, yv, zv, {2'b11, r[1:0]}, r[5:4]);
        end
        drain();
        end_test("exact cancellation");

        for (int i = 0; i < N_STREAM; i++) begin
            r  = next_rand();
            xv = special_operand();
            yv = normal_operand();
            zv = normal_operand();
            issue(xv, yv, zv, r[3:0], r[5:4]);
        end
        drain();
        end_test("back-to-back stream");

        $display("total %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: special/fma16_special.sv
/*
 * special-value path
 * NaN, infinity and zero classification,
 * invalid detection and the special result word
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_special import fma16_pkg::*; (
    input  fp16_u x,
    input  fp16_u y_sel,
    input  fp16_u z_sel,
    output logic  spec_valid,
    output fp16_u spec_word,
    output logic  spec_invalid
);

    logic x_max, y_max, z_max;
    logic x_inf, y_inf, z_inf;
    logic x_zero, y_zero;
    logic snan, qnan;
    logic prod_sign;
    logic zero_times_inf;
    logic inf_minus_inf;
    logic inf_sign;

    assign x_max = (x.nan.exp == `EXP_W'(`EXP_MAX));
    assign y_max = (y_sel.nan.exp == `EXP_W'(`EXP_MAX));
    assign z_max = (z_sel.nan.exp == `EXP_W'(`EXP_MAX));

    // infinity has an all-zero fraction
    assign x_inf = x_max & !x.nan.quiet & (x.nan.payload == '0);
    assign y_inf = y_max & !y_sel.nan.quiet & (y_sel.nan.payload == '0);
    assign z_inf = z_max & !z_sel.nan.quiet & (z_sel.nan.payload == '0);

    // subnormals count as zero
    assign x_zero = (x.nan.exp == '0);
    assign y_zero = (y_sel.nan.exp == '0);

    // signaling: quiet bit clear, payload nonzero
    assign snan = (x_max & !x.nan.quiet & (x.nan.payload != '0))
                | (y_max & !y_sel.nan.quiet & (y_sel.nan.payload != '0))
                | (z_max & !z_sel.nan.quiet & (z_sel.nan.payload != '0));
    assign qnan = (x_max & x.nan.quiet)
                | (y_max & y_sel.nan.quiet)
                | (z_max & z_sel.nan.quiet);

    assign prod_sign = x.nan.sign ^ y_sel.nan.sign;

    assign zero_times_inf = (x_inf & y_zero) | (x_zero & y_inf);
    // infinite product meets an infinite addend of the other sign
    assign inf_minus_inf = (x_inf | y_inf) & z_inf & (prod_sign ^ z_sel.nan.sign);

    assign spec_invalid = snan | zero_times_inf | inf_minus_inf;

    // infinite term decides the sign, product first
    assign inf_sign = (x_inf | y_inf) ? prod_sign : z_sel.nan.sign;

    assign spec_valid = snan | qnan | x_inf | y_inf | z_inf;

    always_comb begin
        if (snan | qnan | zero_times_inf | inf_minus_inf) begin
            spec_word = `QNAN_WORD;
        end else begin
            spec_word = {inf_sign, `INF_MAG};
        end
    end

endmodule

// File: src/fma16.sv
/*
 * fma16 top level
 * operand selection, special and arithmetic paths,
 * result select and the output register
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16 import fma16_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  fp16_u       x,
    input  fp16_u       y,
    input  fp16_u       z,
    input  logic        mul,
    input  logic        add,
    input  logic        negp,
    input  logic        negz,
    input  round_mode_e roundmode,
    output fp16_u       result,
    output logic [3:0]  flags
);

    fp16_u                     y_sel;
    fp16_u                     z_sel;
    logic                      spec_valid;
    fp16_u                     spec_word;
    logic                      spec_invalid;
    logic                      prod_sign;
    logic                      prod_big;
    logic                      eff_sub;
    logic [`SUM_W-1:0]         big_sig;
    logic [`SUM_W-1:0]         small_sig;
    logic signed [`XEXP_W-1:0] ref_exp;
    logic                      sticky;
    logic                      prod_zero;
    logic                      addend_zero;
    logic [`SUM_W-1:0]         norm_sig;
    logic signed [`XEXP_W-1:0] norm_exp;
    logic                      res_sign;
    logic                      exact_zero;
    fp16_u                     rounded_word;
    logic                      ovf;
    logic                      unf;
    logic                      inexact;
    fp16_u                     next_result;
    logic [3:0]                next_flags;

    // mul low forces y to +1, add low forces z to +0
    assign y_sel = mul ? {y.fld.sign ^ negp, y[`FP_W-2:0]} : `ONE_WORD;
    assign z_sel = add ? {z.fld.sign ^ negz, z[`FP_W-2:0]} : '0;

    // NaN, infinity and invalid decisions
    fma16_special i_special (
        .x            (x),
        .y_sel        (y_sel),
        .z_sel        (z_sel),
        .spec_valid   (spec_valid),
        .spec_word    (spec_word),
        .spec_invalid (spec_invalid)
    );

    fma16_mul_align i_mul_align (
        .x           (x),
        .y_sel       (y_sel),
        .z_sel       (z_sel),
        .prod_sign   (prod_sign),
        .prod_big    (prod_big),
        .eff_sub     (eff_sub),
        .big_sig     (big_sig),
        .small_sig   (small_sig),
        .ref_exp     (ref_exp),
        .sticky      (sticky),
        .prod_zero   (prod_zero),
        .addend_zero (addend_zero)
    );

    fma16_add_norm i_add_norm (
        .big_sig     (big_sig),
        .small_sig   (small_sig),
        .ref_exp     (ref_exp),
        .sticky      (sticky),
        .eff_sub     (eff_sub),
        .prod_sign   (prod_sign),
        .prod_big    (prod_big),
        .z_sign      (z_sel.fld.sign),
        .prod_zero   (prod_zero),
        .addend_zero (addend_zero),
        .roundmode   (roundmode),
        .norm_sig    (norm_sig),
        .norm_exp    (norm_exp),
        .res_sign    (res_sign),
        .exact_zero  (exact_zero)
    );

    fma16_round i_round (
        .norm_sig     (norm_sig),
        .norm_exp     (norm_exp),
        .res_sign     (res_sign),
        .sticky       (sticky),
        .roundmode    (roundmode),
        .rounded_word (rounded_word),
        .ovf          (ovf),
        .unf          (unf),
        .inexact      (inexact)
    );

    fma16_result_select i_result_select (
        .spec_valid   (spec_valid),
        .spec_word    (spec_word),
        .spec_invalid (spec_invalid),
        .rounded_word (rounded_word),
        .ovf          (ovf),
        .unf          (unf),
        .inexact      (inexact),
        .exact_zero   (exact_zero),
        .res_sign     (res_sign),
        .roundmode    (roundmode),
        .next_result  (next_result),
        .next_flags   (next_flags)
    );

    // one stage, a new operation every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= next_result;
            flags  <= next_flags;
        end
    end

endmodule

// File: src/fma16_result_select.sv
/*
 * final result and flag selection
 * special values first, then zero, overflow, underflow
 */
`timescale 1ns/10ps
`include "fma16_defines.svh"

module fma16_result_select import fma16_pkg::*; (
    input  logic        spec_valid,
    input  fp16_u       spec_word,
    input  logic        spec_invalid,
    input  fp16_u       rounded_word,
    input  logic        ovf,
    input  logic        unf,
    input  logic        inexact,
    input  logic        exact_zero,
    input  logic        res_sign,
    input  round_mode_e roundmode,
    output fp16_u       next_result,
    output logic [3:0]  next_flags
);

    logic to_maxnum;

    // modes that never round away from zero for this sign
    assign to_maxnum = (roundmode == rm_rz)
                     | ((roundmode == rm_rd) & !res_sign)
                     | ((roundmode == rm_ru) & res_sign);

    // flags are {invalid, overflow, underflow, inexact}
    always_comb begin
        if (spec_valid) begin
            next_result = spec_word;
            next_flags  = {spec_invalid, 3'b000};
        end else if (exact_zero) begin
            next_result = {res_sign, {(`FP_W-1){1'b0}}};
            next_flags  = 4'b0000;
        end else if (ovf) begin
            next_result = {res_sign, (to_maxnum ? `MAXNUM_MAG : `INF_MAG)};
            next_flags  = 4'b0101;
        end else if (unf) begin
            // flush to signed zero
            next_result = {res_sign, {(`FP_W-1){1'b0}}};
            next_flags  = 4'b0011;
        end else begin
            next_result = rounded_word;
            next_flags  = {3'b000, inexact};
        end
    end

endmodule

// File: vlog.f
+incdir+common
+incdir+sim
common/fma16_pkg.sv
special/fma16_special.sv
datapath/fma16_mul_align.sv
datapath/fma16_add_norm.sv
datapath/fma16_round.sv
src/fma16_result_select.sv
src/fma16.sv
sim/tb_fma16.sv
